//--- Bender.yml
package:
  name: arm_controller

sources:
  # RTL, packages first
  - files:
      - src/armIsaPkg.sv
      - src/ctrlPkg.sv
      - src/memAccessDecoder.sv
      - src/controlDecoder.sv
      - src/executeStage.sv
      - src/memWbStage.sv
      - src/armController.sv

  # Testbench with its included model
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tbArmController.sv

//--- files.f
+incdir+verif
src/armIsaPkg.sv
src/ctrlPkg.sv
src/memAccessDecoder.sv
src/controlDecoder.sv
src/executeStage.sv
src/memWbStage.sv
src/armController.sv
verif/tbArmController.sv

//--- src/armController.sv
`timescale 1ns/1ps

module armController (
  input  logic                  clk,
  input  logic                  arstN,
  input  armIsaPkg::instrWord_u instrD,
  input  armIsaPkg::flags_t     aluFlagsE,
  input  logic [1:0]            byteAddrE,   // ALU result bits 1:0
  input  ctrlPkg::stallFlush_t  hazard,
  output ctrlPkg::decodeCtrl_t  decodeOut,
  output ctrlPkg::execCtrl_t    execOut,
  output ctrlPkg::memCtrl_t     memOut,
  output ctrlPkg::wbCtrl_t      wbOut,
  output armIsaPkg::flags_t     flagsOut,
  output logic                  pcWrPending
);

  ctrlPkg::memAttr_t memAttrD;
  armIsaPkg::aluOp_e aluControlD;
  ctrlPkg::memCtrl_t memNext;       // Gated Execute controls
  armIsaPkg::flags_t nextFlags;
  armIsaPkg::flags_t fwdFlags;

  // ==============================
  // Decode, two decoders in parallel
  // ==============================
  memAccessDecoder u_memAccessDecoder (
    .instr (instrD),
    .attr  (memAttrD)
  );

  controlDecoder u_controlDecoder (
    .instr      (instrD),
    .memAttr    (memAttrD),
    .ctrl       (decodeOut),
    .aluControl (aluControlD)
  );

  // Execute, Memory, Writeback
  executeStage u_executeStage (
    .clk        (clk),
    .arstN      (arstN),
    .decodeCtrl (decodeOut),
    .memAttr    (memAttrD),
    .aluControl (aluControlD),
    .cond       (instrD.dp.cond),
    .hazard     (hazard),
    .aluFlags   (aluFlagsE),
    .fwdFlags   (fwdFlags),
    .byteAddr   (byteAddrE),
    .execCtrl   (execOut),
    .memNext    (memNext),
    .nextFlags  (nextFlags)
  );

  memWbStage u_memWbStage (
    .clk       (clk),
    .arstN     (arstN),
    .memNext   (memNext),
    .nextFlags (nextFlags),
    .hazard    (hazard),
    .memCtrl   (memOut),
    .wbCtrl    (wbOut),
    .fwdFlags  (fwdFlags),
    .flags     (flagsOut)
  );

  // Any PC write still in D, E or M
  assign pcWrPending = decodeOut.pcSrc | memNext.pcSrc | memOut.pcSrc;

endmodule

//--- src/armIsaPkg.sv
package armIsaPkg;

  // ==============================
  // Condition field, bits 31:28
  // ==============================
  typedef enum logic [3:0] {
    EQ = 4'h0,  // Z set
    NE = 4'h1,  // Z clear
    CS = 4'h2,  // C set
    CC = 4'h3,  // C clear
    MI = 4'h4,  // Negative
    PL = 4'h5,  // Positive or zero
    VS = 4'h6,  // Overflow
    VC = 4'h7,  // No overflow
    HI = 4'h8,  // Unsigned higher
    LS = 4'h9,  // Unsigned lower or same
    GE = 4'hA,  // Signed greater or equal
    LT = 4'hB,  // Signed less than
    GT = 4'hC,  // Signed greater than
    LE = 4'hD,  // Signed less or equal
    AL = 4'hE,  // Always
    NV = 4'hF   // Never in this core
  } cond_e;

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } aluOp_e;

  // ==============================
  // Instruction word views
  // ==============================
  typedef struct packed {
    cond_e       cond;      // 31:28
    logic [1:0]  opClass;   // 27:26
    logic        immBit;    // 25
    aluOp_e      opcode;    // 24:21
    logic        sBit;      // 20, update flags
    logic [3:0]  rn;
    logic [3:0]  rd;        // 15:12
    logic [11:0] operand2;  // Rotated imm or shifted reg
  } dpFmt_t;

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  opClass;
    logic        immBit;    // Word forms use 1 for register offset
    logic        preIdx;    // P
    logic        up;        // U, add offset when set
    logic        byteBit;   // B, or immediate form for halfwords
    logic        writeBack; // W
    logic        load;      // L
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;    // 7:4 hold the halfword marker
  } lsFmt_t;

  typedef union packed {
    dpFmt_t dp;
    lsFmt_t ls;
  } instrWord_u;

  // NZCV, same order as CPSR[31:28]
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

endpackage

//--- src/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
  input  armIsaPkg::instrWord_u  instr,
  input  ctrlPkg::memAttr_t      memAttr,
  output ctrlPkg::decodeCtrl_t   ctrl,
  output armIsaPkg::aluOp_e      aluControl
);

  logic extSpace;   // Multiply and other 000 forms with bits 7 and 4 set
  logic undefWord;  // Register-offset word class with bit 4 set
  logic isMem;
  logic isDp;
  logic isBranch;
  logic testOp;     // Compare and test ops, flags only

  // ==============================
  // Instruction class
  // ==============================
  assign extSpace  = (instr.dp.opClass == 2'b00) & ~instr.dp.immBit
                   & instr.ls.offset[7] & instr.ls.offset[4];
  assign undefWord = instr.ls.immBit & instr.ls.offset[4];

  // Halfword forms live in class 00, word and byte in class 01
  assign isMem    = memAttr.half | ((instr.ls.opClass == 2'b01) & ~undefWord);
  assign isDp     = (instr.dp.opClass == 2'b00) & ~memAttr.half & ~extSpace;
  assign isBranch = (instr.dp.opClass == 2'b10);

  assign testOp = instr.dp.opcode inside {armIsaPkg::TST, armIsaPkg::TEQ,
                                          armIsaPkg::CMP, armIsaPkg::CMN};

  // ==============================
  // Main control word
  // ==============================
  always_comb begin
    ctrl       = '0;               // Coprocessor, SWI, multiply fall through as no-op
    aluControl = armIsaPkg::ADD;

    if (isMem) begin
      ctrl.regSrc   = memAttr.load ? 2'b00 : 2'b10;  // Stores read Rd on port 2
      ctrl.immSrc   = memAttr.half ? 2'b11 : 2'b01;  // Split 8-bit or 12-bit offset
      ctrl.aluSrc   = ~memAttr.rType;
      ctrl.memtoReg = memAttr.load;
      ctrl.regWrite = memAttr.load;
      ctrl.memWrite = ~memAttr.load;
      // Offset direction from U
      aluControl    = instr.ls.up ? armIsaPkg::ADD : armIsaPkg::SUB;
    end else if (isDp) begin
      ctrl.aluSrc    = instr.dp.immBit;
      ctrl.regWrite  = ~testOp;             // TST/TEQ/CMP/CMN only touch flags
      ctrl.flagWrite = {2{instr.dp.sBit}};
      aluControl     = instr.dp.opcode;
    end else if (isBranch) begin
      ctrl.regSrc = 2'b01;                  // PC as first operand
      ctrl.immSrc = 2'b10;                  // 24-bit word offset
      ctrl.aluSrc = 1'b1;
      ctrl.branch = 1'b1;
    end

    // PC written by a branch or by any result landing in R15
    ctrl.pcSrc = ctrl.branch | ((instr.dp.rd == 4'hF) & ctrl.regWrite);
  end

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

  // ==============================
  // Decode stage
  // ==============================
  typedef struct packed {
    logic [1:0] regSrc;    // Register file read port select
    logic [1:0] immSrc;    // Immediate extend format
    logic       aluSrc;    // 1 selects the immediate
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;     // Writes R15
    logic [1:0] flagWrite; // [1] NZ, [0] CV
  } decodeCtrl_t;

  // Load/store attributes from the access decoder
  typedef struct packed {
    logic half;    // Any halfword-class transfer
    logic signB;   // LDRSB
    logic signH;   // LDRSH
    logic byteAcc;
    logic load;
    logic rType;   // Register offset, shifter needed
  } memAttr_t;

  // ==============================
  // Execute, Memory, Writeback
  // ==============================
  typedef struct packed {
    armIsaPkg::aluOp_e aluControl;
    logic              aluSrc;
    logic              branchTaken;
    logic              condEx;
  } execCtrl_t;

  // Read-data formatting for the Writeback extender
  typedef struct packed {
    logic       loadByte;
    logic [1:0] byteOffset;
    logic       halfword;
    logic       signB;
    logic       signH;
  } loadFmt_t;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;  // Store lane enables
    logic       setFlags;
    loadFmt_t   loadFmt;
  } memCtrl_t;

  typedef struct packed {
    logic     regWrite;
    logic     memtoReg;
    logic     pcSrc;
    loadFmt_t loadFmt;
  } wbCtrl_t;

  // Per-stage hazard controls
  typedef struct packed {
    logic stallE;
    logic flushE;
    logic stallM;
    logic flushM;
    logic stallW;
    logic flushW;
  } stallFlush_t;

  localparam armIsaPkg::flags_t resetFlags = '0;

endpackage

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  ctrlPkg::decodeCtrl_t decodeCtrl,
  input  ctrlPkg::memAttr_t    memAttr,
  input  armIsaPkg::aluOp_e    aluControl,
  input  armIsaPkg::cond_e     cond,
  input  ctrlPkg::stallFlush_t hazard,
  input  armIsaPkg::flags_t    aluFlags,
  input  armIsaPkg::flags_t    fwdFlags,
  input  logic [1:0]           byteAddr,
  output ctrlPkg::execCtrl_t   execCtrl,
  output ctrlPkg::memCtrl_t    memNext,
  output armIsaPkg::flags_t    nextFlags
);

  ctrlPkg::decodeCtrl_t ctrlE;
  ctrlPkg::memAttr_t    attrE;
  armIsaPkg::aluOp_e    aluOpE;
  armIsaPkg::cond_e     condE;
  logic                 validE;     // Cleared by flush so a bubble never passes
  logic                 condPass;
  logic                 condEx;
  logic                 memAccess;
  logic [3:0]           byteMask;

  // ==============================
  // Execute pipeline register
  // ==============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE  <= '0;
      attrE  <= '0;
      aluOpE <= armIsaPkg::AND;
      condE  <= armIsaPkg::EQ;
      validE <= 1'b0;
    end else if (hazard.flushE) begin  // Flush beats stall
      ctrlE  <= '0;
      attrE  <= '0;
      aluOpE <= armIsaPkg::AND;
      condE  <= armIsaPkg::EQ;
      validE <= 1'b0;
    end else if (!hazard.stallE) begin
      ctrlE  <= decodeCtrl;
      attrE  <= memAttr;
      aluOpE <= aluControl;
      condE  <= cond;
      validE <= 1'b1;
    end
  end

  // ==============================
  // Condition check
  // ==============================
  always_comb begin
    case (condE)
      armIsaPkg::EQ: condPass = fwdFlags.z;
      armIsaPkg::NE: condPass = ~fwdFlags.z;
      armIsaPkg::CS: condPass = fwdFlags.c;
      armIsaPkg::CC: condPass = ~fwdFlags.c;
      armIsaPkg::MI: condPass = fwdFlags.n;
      armIsaPkg::PL: condPass = ~fwdFlags.n;
      armIsaPkg::VS: condPass = fwdFlags.v;
      armIsaPkg::VC: condPass = ~fwdFlags.v;
      armIsaPkg::HI: condPass = fwdFlags.c & ~fwdFlags.z;
      armIsaPkg::LS: condPass = ~fwdFlags.c | fwdFlags.z;
      armIsaPkg::GE: condPass = (fwdFlags.n == fwdFlags.v);
      armIsaPkg::LT: condPass = (fwdFlags.n != fwdFlags.v);
      armIsaPkg::GT: condPass = ~fwdFlags.z & (fwdFlags.n == fwdFlags.v);
      armIsaPkg::LE: condPass = fwdFlags.z | (fwdFlags.n != fwdFlags.v);
      armIsaPkg::AL: condPass = 1'b1;
      default:       condPass = 1'b0;  // NV
    endcase
  end

  assign condEx = validE & condPass;

  // New flags merge ALU result into forwarded state
  assign nextFlags.n = ctrlE.flagWrite[1] ? aluFlags.n : fwdFlags.n;
  assign nextFlags.z = ctrlE.flagWrite[1] ? aluFlags.z : fwdFlags.z;
  assign nextFlags.c = ctrlE.flagWrite[0] ? aluFlags.c : fwdFlags.c;
  assign nextFlags.v = ctrlE.flagWrite[0] ? aluFlags.v : fwdFlags.v;

  // Byte lanes from the low address bits
  assign memAccess = ctrlE.memWrite | ctrlE.memtoReg;

  always_comb begin
    if (!memAccess) begin
      byteMask = 4'b0000;
    end else if (attrE.byteAcc) begin
      byteMask = 4'b0001 << byteAddr;                  // One lane
    end else if (attrE.half) begin
      byteMask = byteAddr[1] ? 4'b1100 : 4'b0011;      // Upper or lower half
    end else begin
      byteMask = 4'b1111;                              // Full word
    end
  end

  // Outputs to the datapath
  assign execCtrl.aluControl  = aluOpE;
  assign execCtrl.aluSrc      = ctrlE.aluSrc;
  assign execCtrl.branchTaken = ctrlE.branch & condEx;
  assign execCtrl.condEx      = condEx;

  // Gated controls into the Memory register
  assign memNext.memWrite = ctrlE.memWrite & condEx;
  assign memNext.memtoReg = ctrlE.memtoReg;
  assign memNext.regWrite = ctrlE.regWrite & condEx;
  assign memNext.pcSrc    = ctrlE.pcSrc & condEx;
  assign memNext.byteMask = byteMask;
  assign memNext.setFlags = (ctrlE.flagWrite != 2'b00) & condEx;

  // Load format, only for loads
  assign memNext.loadFmt.loadByte   = ctrlE.memtoReg & attrE.byteAcc;
  assign memNext.loadFmt.byteOffset = ctrlE.memtoReg ? byteAddr : 2'b00;
  assign memNext.loadFmt.halfword   = ctrlE.memtoReg & attrE.half & ~attrE.signB;
  assign memNext.loadFmt.signB      = ctrlE.memtoReg & attrE.signB;
  assign memNext.loadFmt.signH      = ctrlE.memtoReg & attrE.signH;

endmodule

//--- src/memAccessDecoder.sv
`timescale 1ns/1ps

module memAccessDecoder (
  input  armIsaPkg::instrWord_u instr,
  output ctrlPkg::memAttr_t     attr
);

  logic       class000;   // Bits 27:25 all zero
  logic       wordClass;  // LDR/STR word and byte
  logic [3:0] marker;     // Bits 7:4
  logic       halfPlain;  // LDRH/STRH
  logic       signByte;
  logic       signHalf;

  assign class000  = (instr.ls.opClass == 2'b00) & ~instr.ls.immBit;
  assign wordClass = (instr.ls.opClass == 2'b01);
  assign marker    = instr.ls.offset[7:4];

  // ==============================
  // Halfword and signed forms
  // ==============================
  assign halfPlain = class000 & (marker == 4'b1011);
  assign signByte  = class000 & instr.ls.load & (marker == 4'b1101);
  assign signHalf  = class000 & instr.ls.load & (marker == 4'b1111);

  assign attr.half  = halfPlain | signByte | signHalf;
  assign attr.signB = signByte;
  assign attr.signH = signHalf;

  // Byte lanes for B bit or LDRSB
  assign attr.byteAcc = (wordClass & instr.ls.byteBit) | signByte;
  assign attr.load    = instr.ls.load;

  // Register offset forms
  // word class uses I set, halfword class uses bit 22 clear
  assign attr.rType = (wordClass & instr.ls.immBit)
                    | (attr.half & ~instr.ls.byteBit);

endmodule

//--- src/memWbStage.sv
`timescale 1ns/1ps

module memWbStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  ctrlPkg::memCtrl_t    memNext,
  input  armIsaPkg::flags_t    nextFlags,
  input  ctrlPkg::stallFlush_t hazard,
  output ctrlPkg::memCtrl_t    memCtrl,
  output ctrlPkg::wbCtrl_t     wbCtrl,
  output armIsaPkg::flags_t    fwdFlags,
  output armIsaPkg::flags_t    flags
);

  armIsaPkg::flags_t flagsM;     // Flags carried with the M instruction
  armIsaPkg::flags_t flagsW;
  armIsaPkg::flags_t flagsQ;     // Architectural NZCV
  logic              setFlagsW;

  // ==============================
  // Memory register
  // ==============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrl <= '0;
    end else if (hazard.flushM) begin
      memCtrl <= '0;                       // Bubble
    end else if (!hazard.stallM) begin
      memCtrl <= memNext;
    end
  end

  // ==============================
  // Writeback register
  // ==============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbCtrl    <= '0;
      setFlagsW <= 1'b0;
    end else if (hazard.flushW) begin
      wbCtrl    <= '0;
      setFlagsW <= 1'b0;
    end else if (!hazard.stallW) begin
      wbCtrl.regWrite <= memCtrl.regWrite;
      wbCtrl.memtoReg <= memCtrl.memtoReg;
      wbCtrl.pcSrc    <= memCtrl.pcSrc;
      wbCtrl.loadFmt  <= memCtrl.loadFmt;
      setFlagsW       <= memCtrl.setFlags;
    end
  end

  // Flags travel along with the M and W instructions
  always_ff @(posedge clk) begin
    if (!hazard.stallM) begin
      flagsM <= nextFlags;
    end
    if (!hazard.stallW) begin
      flagsW <= flagsM;
    end
  end

  // Commit as the instruction leaves Writeback
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= ctrlPkg::resetFlags;
    end else if (setFlagsW && !hazard.stallW) begin
      flagsQ <= flagsW;
    end
  end

  // Youngest pending update wins
  assign fwdFlags = memCtrl.setFlags ? flagsM
                  : setFlagsW        ? flagsW
                  :                    flagsQ;

  assign flags = flagsQ;

endmodule

//--- verif/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ==============================
// Reference pipeline state
// ==============================
typedef struct packed {
  ctrlPkg::decodeCtrl_t ctrl;
  ctrlPkg::memAttr_t    attr;    // Only half, signB, signH, byteAcc used
  armIsaPkg::aluOp_e    aluOp;
  armIsaPkg::cond_e     cond;
  logic                 valid;   // Real instruction, not a bubble
} modelE_t;

modelE_t           slotE;
ctrlPkg::memCtrl_t slotM;
armIsaPkg::flags_t flagsM;       // Flags travelling with slotM
ctrlPkg::wbCtrl_t  slotW;
logic              setW;         // slotW updates the flags
armIsaPkg::flags_t flagsW;
armIsaPkg::flags_t flagReg;      // Architectural NZCV

task automatic resetModel();
  slotE   = '0;
  slotM   = '0;
  flagsM  = '0;
  slotW   = '0;
  setW    = 1'b0;
  flagsW  = '0;
  flagReg = '0;
endtask

// Instruction word to Execute slot, by class
function automatic modelE_t decodeInstr(input armIsaPkg::instrWord_u w);
  modelE_t    s;
  logic [3:0] mk;
  logic       halfHit;
  logic       memOp;
  s       = '0;
  s.valid = 1'b1;
  s.cond  = w.dp.cond;
  s.aluOp = armIsaPkg::ADD;
  mk      = w.ls.offset[7:4];   // Halfword marker
  halfHit = (w.ls.opClass == 2'b00) && !w.ls.immBit
          && (mk == 4'b1011 || (w.ls.load && (mk == 4'b1101 || mk == 4'b1111)));
  s.attr.half    = halfHit;
  s.attr.signB   = halfHit && (mk == 4'b1101);
  s.attr.signH   = halfHit && (mk == 4'b1111);
  s.attr.byteAcc = s.attr.signB || (w.ls.opClass == 2'b01 && w.ls.byteBit);
  memOp = halfHit || (w.ls.opClass == 2'b01);
  if (memOp) begin
    s.ctrl.regSrc   = w.ls.load ? 2'b00 : 2'b10;
    s.ctrl.immSrc   = halfHit ? 2'b11 : 2'b01;
    s.ctrl.aluSrc   = halfHit ? w.ls.byteBit : !w.ls.immBit;  // Bit 22 or I clear
    s.ctrl.memtoReg = w.ls.load;
    s.ctrl.regWrite = w.ls.load;
    s.ctrl.memWrite = !w.ls.load;
    s.aluOp         = w.ls.up ? armIsaPkg::ADD : armIsaPkg::SUB;
  end else if (w.dp.opClass == 2'b00) begin
    s.ctrl.aluSrc    = w.dp.immBit;
    s.ctrl.regWrite  = (w.dp.opcode[3:2] != 2'b10);  // Opcodes 8 to 11 only compare
    s.ctrl.flagWrite = {w.dp.sBit, w.dp.sBit};
    s.aluOp          = w.dp.opcode;
  end else if (w.dp.opClass == 2'b10) begin
    s.ctrl.regSrc = 2'b01;
    s.ctrl.immSrc = 2'b10;
    s.ctrl.aluSrc = 1'b1;
    s.ctrl.branch = 1'b1;
  end
  s.ctrl.pcSrc = s.ctrl.branch || (w.dp.rd == 4'd15 && s.ctrl.regWrite);
  return s;
endfunction

// Base test picked by cond[3:1], odd codes invert it
function automatic logic condHolds(input armIsaPkg::cond_e cond, input armIsaPkg::flags_t f);
  logic [3:0] code;
  logic       base;
  code = cond;
  case (code[3:1])
    3'd0:    base = f.z;
    3'd1:    base = f.c;
    3'd2:    base = f.n;
    3'd3:    base = f.v;
    3'd4:    base = f.c && !f.z;
    3'd5:    base = (f.n == f.v);
    3'd6:    base = !f.z && (f.n == f.v);
    default: base = 1'b1;          // AL, so NV is never
  endcase
  return code[0] ? !base : base;
endfunction

// Youngest pending flag update first
function automatic armIsaPkg::flags_t fwdModel();
  if (slotM.setFlags) return flagsM;
  if (setW) return flagsW;
  return flagReg;
endfunction

function automatic ctrlPkg::execCtrl_t expectExec();
  ctrlPkg::execCtrl_t e;
  logic               ex;
  ex            = slotE.valid && condHolds(slotE.cond, fwdModel());
  e.aluControl  = slotE.aluOp;
  e.aluSrc      = slotE.ctrl.aluSrc;
  e.branchTaken = slotE.ctrl.branch && ex;
  e.condEx      = ex;
  return e;
endfunction

// Controls headed for the Memory register
function automatic ctrlPkg::memCtrl_t expectMemNext(input logic [1:0] addr);
  ctrlPkg::memCtrl_t m;
  logic              ex;
  ex         = slotE.valid && condHolds(slotE.cond, fwdModel());
  m          = '0;
  m.memWrite = slotE.ctrl.memWrite && ex;
  m.memtoReg = slotE.ctrl.memtoReg;                      // Passes ungated
  m.regWrite = slotE.ctrl.regWrite && ex;
  m.pcSrc    = slotE.ctrl.pcSrc && ex;
  m.setFlags = (slotE.ctrl.flagWrite != 2'b00) && ex;
  if (slotE.ctrl.memWrite || slotE.ctrl.memtoReg) begin
    if (slotE.attr.byteAcc)
      m.byteMask[addr] = 1'b1;
    else if (slotE.attr.half)
      m.byteMask = addr[1] ? 4'b1100 : 4'b0011;
    else
      m.byteMask = 4'b1111;
  end
  if (slotE.ctrl.memtoReg) begin
    m.loadFmt.loadByte   = slotE.attr.byteAcc;
    m.loadFmt.byteOffset = addr;
    m.loadFmt.halfword   = slotE.attr.half && !slotE.attr.byteAcc;  // LDRH or LDRSH
    m.loadFmt.signB      = slotE.attr.signB;
    m.loadFmt.signH      = slotE.attr.signH;
  end
  return m;
endfunction

function automatic armIsaPkg::flags_t flagsAfter(input armIsaPkg::flags_t alu);
  armIsaPkg::flags_t f;
  f = fwdModel();
  if (slotE.ctrl.flagWrite[1]) begin
    f.n = alu.n;
    f.z = alu.z;
  end
  if (slotE.ctrl.flagWrite[0]) begin
    f.c = alu.c;
    f.v = alu.v;
  end
  return f;
endfunction

// One clock edge, oldest stage first so each reads its predecessor's old value
task automatic stepModel(input ctrlPkg::stallFlush_t h, input armIsaPkg::instrWord_u w,
                         input armIsaPkg::flags_t alu, input logic [1:0] addr);
  ctrlPkg::memCtrl_t mNext;
  armIsaPkg::flags_t fNext;
  mNext = expectMemNext(addr);
  fNext = flagsAfter(alu);
  if (setW && !h.stallW) flagReg = flagsW;
  if (h.flushW) begin
    slotW = '0;
    setW  = 1'b0;
  end else if (!h.stallW) begin
    slotW.regWrite = slotM.regWrite;
    slotW.memtoReg = slotM.memtoReg;
    slotW.pcSrc    = slotM.pcSrc;
    slotW.loadFmt  = slotM.loadFmt;
    setW           = slotM.setFlags;
  end
  if (!h.stallW) flagsW = flagsM;
  if (h.flushM) slotM = '0;
  else if (!h.stallM) slotM = mNext;
  if (!h.stallM) flagsM = fNext;
  if (h.flushE) slotE = '0;
  else if (!h.stallE) slotE = decodeInstr(w);
endtask

`endif

//--- verif/tbArmController.sv
`timescale 1ns/1ps

module tbArmController;

  localparam int          modeFree   = 0;             // Random words without hazards
  localparam int          modeHazard = 1;             // Random stall and flush
  localparam int          modeNop    = 2;
  localparam logic [31:0] nopWord    = 32'hEE000000;  // CDP word that decodes to a no-op

  logic                  clk;
  logic                  arstN;
  armIsaPkg::instrWord_u instrD;
  armIsaPkg::flags_t     aluFlagsE;
  logic [1:0]            byteAddrE;
  ctrlPkg::stallFlush_t  hazard;
  ctrlPkg::decodeCtrl_t  decodeOut;
  ctrlPkg::execCtrl_t    execOut;
  ctrlPkg::memCtrl_t     memOut;
  ctrlPkg::wbCtrl_t      wbOut;
  armIsaPkg::flags_t     flagsOut;
  logic                  pcWrPending;
  integer                seed;
  integer                cycle;

  `include "tbModel.svh"

  armController u_armController (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkDecode(input string name, input ctrlPkg::decodeCtrl_t exp,
                             input ctrlPkg::decodeCtrl_t act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %h, actual %h", name, cycle, exp, act));
    end
  endtask

  task automatic checkExec(input string name, input ctrlPkg::execCtrl_t exp,
                           input ctrlPkg::execCtrl_t act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %h, actual %h", name, cycle, exp, act));
    end
  endtask

  task automatic checkMem(input string name, input ctrlPkg::memCtrl_t exp,
                          input ctrlPkg::memCtrl_t act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %h, actual %h", name, cycle, exp, act));
    end
  endtask

  task automatic checkWb(input string name, input ctrlPkg::wbCtrl_t exp,
                         input ctrlPkg::wbCtrl_t act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %h, actual %h", name, cycle, exp, act));
    end
  endtask

  task automatic checkFlags(input string name, input armIsaPkg::flags_t exp,
                            input armIsaPkg::flags_t act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %h, actual %h", name, cycle, exp, act));
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      failRun($sformatf("** Error %s cycle %0d: expected %b, actual %b", name, cycle, exp, act));
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  function automatic logic [31:0] drawInstr();
    logic [31:0] v;
    logic [31:0] r;
    v = $random(seed);                    // Random cond and fields
    r = $random(seed);
    if (r[6:4] == 3'd0) v[31:28] = 4'hE;  // Extra AL
    case (r[2:0])
      3'd0, 3'd6: begin                   // Data-processing register
        v[27:25] = 3'b000;
        v[4]     = 1'b0;
      end
      3'd1, 3'd7: v[27:25] = 3'b001;      // Data-processing immediate
      3'd2: begin                         // LDR/STR word or byte
        v[27:26] = 2'b01;
        if (v[25]) v[4] = 1'b0;
      end
      3'd3: begin                         // LDRH/STRH/LDRSB/LDRSH
        v[27:25] = 3'b000;
        v[7:4]   = (r[9:8] == 2'd0) ? 4'b1011 : (r[8] ? 4'b1101 : 4'b1111);
        if (v[6]) v[20] = 1'b1;           // Signed forms are loads only
      end
      3'd4:    v[27:25] = 3'b101;         // Branch
      default: v[27:26] = 2'b11;          // Coprocessor
    endcase
    return v;
  endfunction

  function automatic ctrlPkg::stallFlush_t drawHazard();
    ctrlPkg::stallFlush_t h;
    logic [31:0]          r;
    r        = $random(seed);
    h.stallW = (r[2:0] == 3'd0);
    h.stallM = h.stallW | (r[5:3] == 3'd0);  // A stall holds every earlier stage
    h.stallE = h.stallM | (r[8:6] == 3'd0);
    h.flushE = (r[12:9] == 4'd0);
    h.flushM = (r[16:13] == 4'd0);
    h.flushW = (r[20:17] == 4'd0);
    return h;
  endfunction

  // All outputs against the model at the falling edge
  task automatic compareAll();
    modelE_t           dec;
    ctrlPkg::memCtrl_t expNext;
    dec     = decodeInstr(instrD);
    expNext = expectMemNext(byteAddrE);
    checkDecode("decode controls", dec.ctrl, decodeOut);
    checkExec("execute controls", expectExec(), execOut);
    checkMem("memory controls", slotM, memOut);
    checkWb("writeback controls", slotW, wbOut);
    checkFlags("architectural flags", flagReg, flagsOut);
    checkBit("pending PC write", dec.ctrl.pcSrc | expNext.pcSrc | slotM.pcSrc, pcWrPending);
    if (slotE.valid && slotE.cond == armIsaPkg::AL) checkBit("AL executes", 1'b1, execOut.condEx);
    if (slotE.cond == armIsaPkg::NV) checkBit("NV never executes", 1'b0, execOut.condEx);
  endtask

  task automatic runCycle(input int mode);
    logic [31:0]          w;
    ctrlPkg::stallFlush_t h;
    logic [31:0]          r;
    w = (mode == modeNop) ? nopWord : drawInstr();
    h = '0;
    if (mode == modeHazard) h = drawHazard();
    r = $random(seed);
    @(posedge clk);
    arstN     <= 1'b1;
    instrD    <= w;
    aluFlagsE <= r[3:0];
    byteAddrE <= r[5:4];
    hazard    <= h;
    @(negedge clk);
    compareAll();
    stepModel(hazard, instrD, aluFlagsE, byteAddrE);  // Edge still to come
    cycle = cycle + 1;
  endtask

  task automatic drainPipeline();
    integer waited;
    waited = 0;
    while (slotE.ctrl != '0 || slotM != '0 || slotW != '0 || setW) begin
      if (waited >= 10) begin
        failRun("Timeout: pipeline did not drain within 10 cycles of no-op words");
      end else begin
        runCycle(modeNop);
        waited = waited + 1;
      end
    end
  endtask

  initial begin
    seed      = 32'haa4c;
    cycle     = 0;
    arstN     = 1'b0;
    instrD    = '0;
    aluFlagsE = '0;
    byteAddrE = 2'b00;
    hazard    = '0;
    resetModel();
    repeat (4) begin           // Every registered output zero while reset is low
      @(posedge clk);
      @(negedge clk);
      compareAll();
    end
    repeat (400) runCycle(modeFree);
    repeat (400) runCycle(modeHazard);
    drainPipeline();           // Last flag writes reach the register
    $display("Simulation passed");
    $finish;
  end

endmodule
